//--- compile.f
+incdir+src
src/cdc_pkg.sv
src/gray_sync.sv
src/dual_clock_ram.sv
src/dual_clock_fifo.sv
src/clock_domain_crossing.sv
testbench/cdc_sva.sv
testbench/tb_clock_domain_crossing.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the stream crossing testbench with Verilator and run it.
# The exit status is the simulator's, nonzero when the testbench stops with $fatal.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_clock_domain_crossing \
    -f compile.f -o tb_sim \
    && ./obj_dir/tb_sim \
    && echo "simulation run finished" \
    || { echo "simulation run failed"; exit 1; }

//--- src/cdc_config.svh
// Build-time sizes of the stream crossing.
// Data width, memory address width and almost-full margin.
`ifndef CDC_CONFIG_SVH
`define CDC_CONFIG_SVH

// Bits per stream word.
`define CDC_WIDTH 8

// Memory address bits, giving a depth of 16 words.
`define CDC_ADDRESS_WIDTH 4

// Free words kept in reserve before rx_tready drops.
`define CDC_ALMOST_FULL_MARGIN 4

`endif

//--- src/cdc_pkg.sv
// Shared types of the stream crossing.
// Data word, memory address, pointer/count and tx state encoding.
`include "cdc_config.svh"

package cdc_pkg;

    // One stream word.
    typedef logic [`CDC_WIDTH-1:0] data_t;

    // Memory location.
    typedef logic [`CDC_ADDRESS_WIDTH-1:0] addr_t;

    // Pointer or fill count, one extra wrap bit to tell full from empty.
    typedef logic [`CDC_ADDRESS_WIDTH:0] ptr_t;

    // Output side states.
    typedef enum logic [0:0] {
        TX_IDLE,    // Nothing on the output register.
        TX_DATA     // Word presented with tx_tvalid high.
    } tx_state_t;

endpackage

//--- src/clock_domain_crossing.sv
// Valid/ready stream crossing from rx_aclk to tx_aclk.
// Registered write stage with almost-full throttle, tx FSM over a dual-clock FIFO.
`timescale 1ns/1ps
`include "cdc_config.svh"

module clock_domain_crossing (
    input  logic           areset_n,    // Async reset, both domains.
    input  logic           rx_aclk,     // Input stream clock.
    input  logic           rx_tvalid,   // Input word offered.
    input  cdc_pkg::data_t rx_tdata,    // Input word.
    output logic           rx_tready,   // Room for more input.
    input  logic           tx_aclk,     // Output stream clock.
    input  logic           tx_tready,   // Sink takes the word.
    output logic           tx_tvalid,   // Output word presented.
    output cdc_pkg::data_t tx_tdata     // Output word.
);
    logic               write_enable;   // Registered rx handshake.
    cdc_pkg::data_t     write_data;     // Registered rx word.
    cdc_pkg::ptr_t      wr_used;        // Writer's view of the fill level.
    logic               below_limit;    // Enough room left to keep accepting.
    logic               read_enable;    // Pop request, tx_aclk domain.
    cdc_pkg::data_t     read_data;      // Word from the FIFO read register.
    logic               rd_empty;       // FIFO empty, tx_aclk domain.
    cdc_pkg::tx_state_t tx_state;       // Output side FSM.

    // Margin covers the words already in flight when rx_tready is updated.
    always_comb below_limit = (wr_used < cdc_pkg::ptr_t'((1 << `CDC_ADDRESS_WIDTH)
                                                         - `CDC_ALMOST_FULL_MARGIN));

    always_ff @(posedge rx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            write_enable <= 1'b0;
            rx_tready    <= 1'b0;   // Rises one cycle after release.
        end
        else begin
            write_enable <= rx_tvalid && rx_tready;     // Write lands one cycle later.
            rx_tready    <= below_limit;
        end
    end

    always_ff @(posedge rx_aclk) begin
        write_data <= rx_tdata;     // Only used when write_enable is set.
    end

    dual_clock_fifo fifo (
        .wr_clk       (rx_aclk),
        .rd_clk       (tx_aclk),
        .areset_n     (areset_n),
        .write_enable (write_enable),
        .write_data   (write_data),
        .wr_used      (wr_used),
        .read_enable  (read_enable),
        .read_data    (read_data),
        .rd_empty     (rd_empty)
    );

    always_ff @(posedge tx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            tx_state <= cdc_pkg::TX_IDLE;
        end
        else begin
            unique case (tx_state)
                cdc_pkg::TX_IDLE: if (!rd_empty) tx_state <= cdc_pkg::TX_DATA;  // Word on its way.
                cdc_pkg::TX_DATA: if (tx_tready && rd_empty) tx_state <= cdc_pkg::TX_IDLE;
            endcase
        end
    end

    // Read in idle to fill the output register, then only on acceptance.
    always_comb begin
        unique case (tx_state)
            cdc_pkg::TX_IDLE: read_enable = !rd_empty;
            cdc_pkg::TX_DATA: read_enable = !rd_empty && tx_tready;
        endcase
    end

    always_comb tx_tvalid = (tx_state == cdc_pkg::TX_DATA);
    always_comb tx_tdata  = read_data;  // RAM register holds it while stalled.

endmodule

//--- src/dual_clock_fifo.sv
// Dual-clock FIFO with Gray-coded pointer crossing.
// Write-side fill count, read-side empty flag, non-showahead read data.
`timescale 1ns/1ps
`include "cdc_config.svh"

module dual_clock_fifo (
    input  logic           wr_clk,          // Write domain clock.
    input  logic           rd_clk,          // Read domain clock.
    input  logic           areset_n,        // Async reset for both domains.
    input  logic           write_enable,    // Push write_data.
    input  cdc_pkg::data_t write_data,      // Word to push.
    output cdc_pkg::ptr_t  wr_used,         // Fill count seen by the writer.
    input  logic           read_enable,     // Pop into read_data.
    output cdc_pkg::data_t read_data,       // Popped word, one cycle later.
    output logic           rd_empty         // Nothing left for the reader.
);
    cdc_pkg::ptr_t  wr_ptr;         // Next write slot, wr_clk domain.
    cdc_pkg::ptr_t  rd_ptr;         // Next read slot, rd_clk domain.
    cdc_pkg::ptr_t  wr_ptr_sync;    // Write pointer as seen on rd_clk.
    cdc_pkg::ptr_t  rd_ptr_sync;    // Read pointer as seen on wr_clk.
    cdc_pkg::addr_t wr_addr;        // Memory write location.
    cdc_pkg::addr_t rd_addr;        // Memory read location.

    // Writer never pushes into a full FIFO, so no overflow guard.
    always_ff @(posedge wr_clk or negedge areset_n) begin
        if (!areset_n) begin
            wr_ptr <= '0;
        end
        else if (write_enable) begin
            wr_ptr <= wr_ptr + 1'b1;    // Wrap bit toggles every depth words.
        end
    end

    // Reader never pops an empty FIFO either.
    always_ff @(posedge rd_clk or negedge areset_n) begin
        if (!areset_n) begin
            rd_ptr <= '0;
        end
        else if (read_enable) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Low bits index the memory, top bit only tells laps apart.
    always_comb wr_addr = wr_ptr[`CDC_ADDRESS_WIDTH-1:0];
    always_comb rd_addr = rd_ptr[`CDC_ADDRESS_WIDTH-1:0];

    // Synced read pointer lags, so the count errs high and stays safe.
    always_comb wr_used = wr_ptr - rd_ptr_sync;     // Modulo 2*depth difference.

    // Synced write pointer lags, so empty clears late and never early.
    always_comb rd_empty = (rd_ptr == wr_ptr_sync);

    gray_sync wr_ptr_crossing (
        .src_clk  (wr_clk),
        .dst_clk  (rd_clk),
        .areset_n (areset_n),
        .src_ptr  (wr_ptr),
        .dst_ptr  (wr_ptr_sync)
    );

    gray_sync rd_ptr_crossing (
        .src_clk  (rd_clk),
        .dst_clk  (wr_clk),
        .areset_n (areset_n),
        .src_ptr  (rd_ptr),
        .dst_ptr  (rd_ptr_sync)
    );

    dual_clock_ram ram (
        .wr_clk  (wr_clk),
        .rd_clk  (rd_clk),
        .wr_en   (write_enable),
        .wr_addr (wr_addr),
        .wr_data (write_data),
        .rd_en   (read_enable),
        .rd_addr (rd_addr),
        .rd_data (read_data)    // Registered, no showahead.
    );

endmodule

//--- src/dual_clock_ram.sv
// Dual-port word memory for the crossing FIFO.
// Write port on wr_clk, registered read port on rd_clk.
`timescale 1ns/1ps
`include "cdc_config.svh"

module dual_clock_ram (
    input  logic           wr_clk,      // Write clock.
    input  logic           rd_clk,      // Read clock.
    input  logic           wr_en,       // Store wr_data at wr_addr.
    input  cdc_pkg::addr_t wr_addr,     // Write location.
    input  cdc_pkg::data_t wr_data,     // Word to store.
    input  logic           rd_en,       // Load read register.
    input  cdc_pkg::addr_t rd_addr,     // Read location.
    output cdc_pkg::data_t rd_data      // Registered read word.
);
    cdc_pkg::data_t mem [0:(1 << `CDC_ADDRESS_WIDTH) - 1];  // Storage array.

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Holds the last word while rd_en is low, so stalled output stays put.
    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];    // Valid one rd_clk cycle after request.
        end
    end

endmodule

//--- src/gray_sync.sv
// Pointer synchronizer between two clock domains.
// Gray register on the source side, two flops and binary decode on the destination side.
`timescale 1ns/1ps
`include "cdc_config.svh"

module gray_sync (
    input  logic          src_clk,      // Source domain clock.
    input  logic          dst_clk,      // Destination domain clock.
    input  logic          areset_n,     // Shared async reset.
    input  cdc_pkg::ptr_t src_ptr,      // Binary pointer, source domain.
    output cdc_pkg::ptr_t dst_ptr       // Binary pointer, destination domain.
);
    cdc_pkg::ptr_t src_gray;            // Gray code held in source domain.
    cdc_pkg::ptr_t meta_gray;           // First capture flop, may go metastable.
    cdc_pkg::ptr_t sync_gray;           // Second flop, settled value.

    // One bit flips per pointer step, so a capture mid-change is off by one at most.
    always_ff @(posedge src_clk or negedge areset_n) begin
        if (!areset_n) begin
            src_gray <= '0;
        end
        else begin
            src_gray <= src_ptr ^ (src_ptr >> 1);   // Binary to Gray.
        end
    end

    always_ff @(posedge dst_clk or negedge areset_n) begin
        if (!areset_n) begin
            meta_gray <= '0;
            sync_gray <= '0;
        end
        else begin
            meta_gray <= src_gray;      // Crosses the clock boundary here.
            sync_gray <= meta_gray;
        end
    end

    // Each binary bit is the XOR of all Gray bits at and above it.
    always_comb begin
        for (int i = 0; i <= `CDC_ADDRESS_WIDTH; i++) begin
            dst_ptr[i] = ^(sync_gray >> i);
        end
    end

endmodule

//--- testbench/cdc_sva.sv
// Protocol assertions for the stream crossing top level and their bind.
// Reset values of both streams and output hold under back-pressure.
`timescale 1ns/1ps
`include "cdc_config.svh"

module cdc_sva (
    input logic           areset_n,     // Shared async reset.
    input logic           rx_aclk,      // Input stream clock.
    input logic           rx_tready,    // Input side throttle.
    input logic           tx_aclk,      // Output stream clock.
    input logic           tx_tready,    // Sink acceptance.
    input logic           tx_tvalid,    // Output word presented.
    input cdc_pkg::data_t tx_tdata      // Output word.
);

    // Input side stays closed through reset and on the first edge after it.
    rx_ready_in_reset: assert property (@(posedge rx_aclk) !areset_n |-> !rx_tready)
        else $error("rx_tready high while areset_n is low");
    rx_ready_at_release: assert property (@(posedge rx_aclk) $rose(areset_n) |-> !rx_tready)
        else $error("rx_tready high on the first rx_aclk edge after reset");

    tx_valid_in_reset: assert property (@(posedge tx_aclk) !areset_n |-> !tx_tvalid)
        else $error("tx_tvalid high while areset_n is low");
    tx_valid_at_release: assert property (@(posedge tx_aclk) $rose(areset_n) |-> !tx_tvalid)
        else $error("tx_tvalid high on the first tx_aclk edge after reset");

    // A stalled word stays on the bus unchanged.
    tx_hold_on_stall: assert property (@(posedge tx_aclk) disable iff (!areset_n)
        tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata))
        else $error("tx_tvalid or tx_tdata changed while tx_tready was low");

endmodule

bind clock_domain_crossing cdc_sva sva (
    .areset_n  (areset_n),
    .rx_aclk   (rx_aclk),
    .rx_tready (rx_tready),
    .tx_aclk   (tx_aclk),
    .tx_tready (tx_tready),
    .tx_tvalid (tx_tvalid),
    .tx_tdata  (tx_tdata)
);

//--- testbench/tb_clock_domain_crossing.sv
// Stream crossing testbench with two clocks, phased random traffic and a queue model.
// Compare tasks for words and counts, drain check and watchdog.
`timescale 1ns/1ps
`include "cdc_config.svh"

module tb_clock_domain_crossing;

    localparam int      WORDS          = 400;      // Words sent over the whole run.
    localparam int      PHASE_WORDS    = 100;      // Words per traffic phase.
    localparam int      RX_PERIOD      = 8;        // rx_aclk period in ns.
    localparam realtime TX_HALF        = 5.5;      // Half of the 11 ns tx_aclk period.
    localparam int      RESET_CYCLES   = 8;
    localparam int      STALL_CYCLES   = 60;       // tx_aclk cycles with tx_tready low.
    localparam int      DRAIN_CYCLES   = 20;       // Idle check after the last word.
    localparam int      FILL_LIMIT     = (1 << `CDC_ADDRESS_WIDTH) + 1;  // Memory plus output.
    localparam int      TIMEOUT_NS     = WORDS * 40 * 4 + STALL_CYCLES * 11;

    logic           areset_n;
    logic           rx_aclk;
    logic           rx_tvalid;
    cdc_pkg::data_t rx_tdata;
    logic           rx_tready;
    logic           tx_aclk;
    logic           tx_tready;
    logic           tx_tvalid;
    cdc_pkg::data_t tx_tdata;

    integer         seed;                       // Shared $random seed.
    int             phase = 0;                  // 0 free, 1 rx gaps, 2 tx gaps, 3 stall.
    logic           stalling = 1'b0;            // tx_tready forced low.
    logic           stall_done = 1'b0;
    logic           saw_throttle = 1'b0;        // rx_tready dropped during the stall.
    int             delivered = 0;              // Words taken on tx.
    cdc_pkg::data_t model [$];                  // Accepted, not yet delivered.

    clock_domain_crossing uut (
        .areset_n  (areset_n),
        .rx_aclk   (rx_aclk),
        .rx_tvalid (rx_tvalid),
        .rx_tdata  (rx_tdata),
        .rx_tready (rx_tready),
        .tx_aclk   (tx_aclk),
        .tx_tready (tx_tready),
        .tx_tvalid (tx_tvalid),
        .tx_tdata  (tx_tdata)
    );

    initial begin
        rx_aclk = 1'b0;
        forever #(RX_PERIOD / 2) rx_aclk = ~rx_aclk;
    end

    initial begin
        tx_aclk = 1'b0;
        forever #(TX_HALF) tx_aclk = ~tx_aclk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_data(input string name, input cdc_pkg::data_t expected,
                              input cdc_pkg::data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: %s expected 0x%02h, got 0x%02h",
                                $time, name, expected, actual));
        end
    endtask

    // Counts are upper bounds; a bound of zero demands an exact zero.
    task automatic check_count(input string name, input cdc_pkg::ptr_t limit,
                               input cdc_pkg::ptr_t actual);
        if (actual > limit) begin
            abort_run($sformatf("mismatch at %0t: %s expected at most %0d, got %0d",
                                $time, name, limit, actual));
        end
    endtask

    // Offer one word and hold it until the handshake edge has passed.
    task automatic send_word(input cdc_pkg::data_t word);
        rx_tvalid = 1'b1;
        rx_tdata  = word;
        while (!rx_tready) @(negedge rx_aclk);  // Ready is stable between edges.
        @(negedge rx_aclk);                     // Transfer on the rising edge before.
    endtask

    always @(posedge rx_aclk) begin
        if (areset_n && rx_tvalid && rx_tready) begin
            model.push_back(rx_tdata);
            if (stalling) begin
                check_count("words in flight", cdc_pkg::ptr_t'(FILL_LIMIT),
                            cdc_pkg::ptr_t'(model.size()));
            end
        end
        if (stalling && !rx_tready) begin
            saw_throttle = 1'b1;
        end
    end

    always @(posedge tx_aclk) begin
        if (areset_n && tx_tvalid && tx_tready) begin
            if (model.size() == 0) begin
                abort_run("tx delivered a word that was never accepted on rx");
            end
            else begin
                check_data("tx_tdata", model.pop_front(), tx_tdata);
                delivered++;
            end
        end
    end

    // Output sink, by phase.
    initial begin
        int r;
        tx_tready = 1'b0;
        @(posedge areset_n);
        forever begin
            @(negedge tx_aclk);
            if (phase == 3 && !stall_done) begin
                tx_tready = 1'b0;
                stalling  = 1'b1;
                repeat (STALL_CYCLES) @(negedge tx_aclk);
                stalling   = 1'b0;
                stall_done = 1'b1;
                if (!saw_throttle) begin
                    abort_run("rx_tready never dropped while tx_tready was held low");
                end
                tx_tready = 1'b1;   // Release the stall.
            end
            else if (phase == 2) begin
                r = $random(seed);
                tx_tready = r[0];
            end
            else begin
                tx_tready = 1'b1;
            end
        end
    end

    // Reset, input traffic, drain and final checks.
    initial begin
        int r;
        int quiet;
        seed      = 32'hab201f8b;
        areset_n  = 1'b0;
        rx_tvalid = 1'b0;
        rx_tdata  = '0;
        repeat (RESET_CYCLES) @(negedge rx_aclk);
        areset_n = 1'b1;
        for (int i = 0; i < WORDS; i++) begin
            phase = i / PHASE_WORDS;
            if (phase == 1) begin
                r = $random(seed);
                while (r[0]) begin      // Random idle cycles between words.
                    rx_tvalid = 1'b0;
                    @(negedge rx_aclk);
                    r = $random(seed);
                end
            end
            send_word(cdc_pkg::data_t'($random(seed)));
        end
        rx_tvalid = 1'b0;
        quiet = 0;
        while (quiet < DRAIN_CYCLES) begin     // Output idle for a whole window.
            @(negedge tx_aclk);
            quiet = tx_tvalid ? 0 : quiet + 1;
        end
        check_count("words left in model", '0,
                    cdc_pkg::ptr_t'((model.size() > FILL_LIMIT) ? FILL_LIMIT : model.size()));
        repeat (DRAIN_CYCLES) begin
            @(negedge tx_aclk);
            if (tx_tvalid) begin
                abort_run("tx_tvalid high after all words were delivered");
            end
        end
        $display("No errors");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run($sformatf("timeout after %0d ns, only %0d of %0d words delivered",
                            TIMEOUT_NS, delivered, WORDS));
    end

endmodule
